//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing
TOP       ?= ex_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- build.f
+incdir+hdl
hdl/ex_pkg.sv
hdl/ex_alu.sv
hdl/ex_muldiv.sv
hdl/ex_commit.sv
hdl/ex_top.sv
verification/ex_tb_clk.sv
verification/ex_tb.sv

//--- hdl/ex_alu.sv
`timescale 1ns/1ps
`include "ex_defs.svh"

module ex_alu (
    input  ex_pkg::ex_req_t req_i,
    output ex_pkg::ex_res_t res_o
);

    import ex_pkg::*;

    logic [`EX_XLEN-1:0]     op1;
    logic [`EX_XLEN-1:0]     op2;
    logic [`EX_SHAMT_W-1:0]  shamt;
    logic [`EX_SHAMTW_W-1:0] shamtw;

    logic [`EX_XLEN-1:0]     add_res;
    logic [`EX_XLEN-1:0]     sub_res;
    logic [`EX_XLEN-1:0]     sra_res;
    logic [`EX_XLEN-1:0]     link_addr;

    logic [31:0]             addw_res;
    logic [31:0]             subw_res;
    logic [31:0]             sllw_res;
    logic [31:0]             srlw_res;
    logic signed [31:0]      op1_w;
    logic signed [31:0]      sraw_res;

    logic                    lt_s;
    logic                    lt_u;
    logic                    eq;
    logic                    cond;
    logic [`EX_XLEN-1:0]     alu_data;

    assign op1    = req_i.op1;
    assign op2    = req_i.op2;
    assign shamt  = op2[`EX_SHAMT_W-1:0];
    assign shamtw = op2[`EX_SHAMTW_W-1:0];

    assign add_res = op1 + op2;
    assign sub_res = op1 - op2;
    assign sra_res = $signed(op1) >>> shamt;

    // word forms work on the low half only
    assign addw_res = op1[31:0] + op2[31:0];
    assign subw_res = op1[31:0] - op2[31:0];
    assign sllw_res = op1[31:0] << shamtw;
    assign srlw_res = op1[31:0] >> shamtw;
    assign op1_w    = op1[31:0];
    assign sraw_res = op1_w >>> shamtw;

    assign lt_s = $signed(op1) < $signed(op2);
    assign lt_u = op1 < op2;
    assign eq   = op1 == op2;

    assign link_addr = req_i.pc + `EX_XLEN'(4);

    always_comb begin
        alu_data = '0;
        case (req_i.op)
            OP_ADD:  alu_data = add_res;
            OP_SUB:  alu_data = sub_res;
            OP_SLT:  alu_data = {{(`EX_XLEN-1){1'b0}}, lt_s};
            OP_SLTU: alu_data = {{(`EX_XLEN-1){1'b0}}, lt_u};
            OP_XOR:  alu_data = op1 ^ op2;
            OP_OR:   alu_data = op1 | op2;
            OP_AND:  alu_data = op1 & op2;
            OP_SLL:  alu_data = op1 << shamt;
            OP_SRL:  alu_data = op1 >> shamt;
            OP_SRA:  alu_data = sra_res;
            OP_ADDW: alu_data = {{(`EX_XLEN-32){addw_res[31]}}, addw_res};
            OP_SUBW: alu_data = {{(`EX_XLEN-32){subw_res[31]}}, subw_res};
            OP_SLLW: alu_data = {{(`EX_XLEN-32){sllw_res[31]}}, sllw_res};
            OP_SRLW: alu_data = {{(`EX_XLEN-32){srlw_res[31]}}, srlw_res};
            OP_SRAW: alu_data = {{(`EX_XLEN-32){sraw_res[31]}}, sraw_res};
            // return address for the jump
            OP_JAL:  alu_data = link_addr;
            default: alu_data = '0;
        endcase
    end

    // branch condition
    always_comb begin
        case (req_i.op)
            OP_BEQ:  cond = eq;
            OP_BNE:  cond = ~eq;
            OP_BLT:  cond = lt_s;
            OP_BGE:  cond = ~lt_s;
            OP_BLTU: cond = lt_u;
            OP_BGEU: cond = ~lt_u;
            OP_JAL:  cond = 1'b1;
            default: cond = 1'b0;
        endcase
    end

    assign res_o.rd_data      = alu_data;
    assign res_o.rd_addr      = req_i.rd_addr;
    assign res_o.rd_ena       = req_i.rd_ena;
    assign res_o.branch_taken = cond;
    assign res_o.branch_pc    = cond ? req_i.pc + req_i.imm : '0;

endmodule

//--- hdl/ex_commit.sv
`timescale 1ns/1ps
`include "ex_defs.svh"

module ex_commit (
    input  logic                clk,
    input  logic                rst_n_i,

    input  ex_pkg::ex_req_t     req_i,
    input  logic                req_valid_i,
    output logic                req_ready_o,

    input  ex_pkg::ex_res_t     alu_res_i,

    output logic                md_start_o,
    input  logic                md_done_i,
    input  logic [`EX_XLEN-1:0] md_result_i,

    output ex_pkg::ex_res_t     res_o,
    output logic                res_valid_o,
    input  logic                res_ready_i
);

    import ex_pkg::*;

    logic       busy_q;
    logic       res_valid_q;
    ex_res_t    res_q;
    logic [4:0] md_rd_addr_q;
    logic       md_rd_ena_q;

    logic       req_fire;
    logic       res_fire;
    logic       is_md;

    assign is_md    = ex_op_class(req_i.op) == CLS_MULDIV;
    assign res_fire = res_valid_q & res_ready_i;

    // output slot free now or emptied this cycle
    assign req_ready_o = ~busy_q & (~res_valid_q | res_ready_i);
    assign req_fire    = req_valid_i & req_ready_o;
    assign md_start_o  = req_fire & is_md;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q      <= 1'b0;
            res_valid_q <= 1'b0;
        end else begin
            if (res_fire) begin
                res_valid_q <= 1'b0;
            end
            if ((req_fire & ~is_md) | md_done_i) begin
                res_valid_q <= 1'b1;
            end

            if (md_start_o) begin
                busy_q <= 1'b1;
            end else if (md_done_i) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (md_start_o) begin
            md_rd_addr_q <= req_i.rd_addr;
            md_rd_ena_q  <= req_i.rd_ena;
        end

        if (req_fire & ~is_md) begin
            res_q <= alu_res_i;
        end else if (md_done_i) begin
            res_q <= '{rd_data:      md_result_i,
                       rd_addr:      md_rd_addr_q,
                       rd_ena:       md_rd_ena_q,
                       branch_taken: 1'b0,
                       branch_pc:    '0};
        end
    end

    assign res_o       = res_q;
    assign res_valid_o = res_valid_q;

endmodule

//--- hdl/ex_defs.svh
`ifndef EX_DEFS_SVH
`define EX_DEFS_SVH

// integer data path width
`define EX_XLEN 64

// shift amount taken from op2, register and word forms
`define EX_SHAMT_W 6
`define EX_SHAMTW_W 5

// one iteration per operand bit
`define EX_MD_STEPS 64

`endif

//--- hdl/ex_muldiv.sv
`timescale 1ns/1ps
`include "ex_defs.svh"

module ex_muldiv (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                start_i,
    input  ex_pkg::ex_op_e      op_i,
    input  logic [`EX_XLEN-1:0] op1_i,
    input  logic [`EX_XLEN-1:0] op2_i,
    output logic [`EX_XLEN-1:0] result_o,
    output logic                done_o
);

    import ex_pkg::*;

    localparam int XW    = `EX_XLEN;
    localparam int CNT_W = $clog2(`EX_MD_STEPS);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`EX_MD_STEPS - 1);

    ex_md_state_e       state_q;
    logic [CNT_W-1:0]   cnt_q;

    ex_op_e             op_q;
    logic               neg_q;
    logic               b_zero_q;
    logic [XW-1:0]      opb_q;
    logic [2*XW-1:0]    acc_q;
    logic [XW-1:0]      result_q;

    logic               signed_op;
    logic               a_neg;
    logic               b_neg;
    logic [XW-1:0]      a_mag;
    logic [XW-1:0]      b_mag;
    logic               start_neg;

    logic               is_div;
    logic [XW:0]        mul_sum;
    logic [XW:0]        div_trial;
    logic [2*XW-1:0]    acc_step;

    logic [2*XW-1:0]    prod;
    logic [XW-1:0]      quot;
    logic [XW-1:0]      rem;
    logic [XW-1:0]      fix_res;

    // operand magnitudes, MUL low half is sign independent
    assign signed_op = (op_i == OP_MULH) || (op_i == OP_DIV) || (op_i == OP_REM);
    assign a_neg     = signed_op & op1_i[XW-1];
    assign b_neg     = signed_op & op2_i[XW-1];
    assign a_mag     = a_neg ? -op1_i : op1_i;
    assign b_mag     = b_neg ? -op2_i : op2_i;
    // remainder follows the dividend sign
    assign start_neg = (op_i == OP_REM) ? a_neg : (a_neg ^ b_neg);

    assign is_div = (op_q == OP_DIV) || (op_q == OP_DIVU) ||
                    (op_q == OP_REM) || (op_q == OP_REMU);

    // shift-add: add multiplicand into the high half, shift right
    assign mul_sum = {1'b0, acc_q[2*XW-1:XW]} + (acc_q[0] ? {1'b0, opb_q} : '0);

    // restoring: partial remainder in the high half, quotient fills the low half
    assign div_trial = acc_q[2*XW-1:XW-1] - {1'b0, opb_q};

    always_comb begin
        if (!is_div) begin
            acc_step = {mul_sum, acc_q[XW-1:1]};
        end else if (div_trial[XW]) begin
            acc_step = {acc_q[2*XW-2:0], 1'b0};
        end else begin
            acc_step = {div_trial[XW-1:0], acc_q[XW-2:0], 1'b1};
        end
    end

    assign prod = neg_q ? -acc_q : acc_q;
    assign quot = neg_q ? -acc_q[XW-1:0] : acc_q[XW-1:0];
    assign rem  = neg_q ? -acc_q[2*XW-1:XW] : acc_q[2*XW-1:XW];

    // a zero divisor leaves rem at op1 already
    // overflow also lands right: 2^63 / 1 with positive sign gives op1, rem 0
    always_comb begin
        case (op_q)
            OP_MUL:           fix_res = prod[XW-1:0];
            OP_MULH, OP_MULHU: fix_res = prod[2*XW-1:XW];
            OP_DIV, OP_DIVU:  fix_res = b_zero_q ? '1 : quot;
            OP_REM, OP_REMU:  fix_res = rem;
            default:          fix_res = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= MD_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                MD_IDLE: begin
                    if (start_i) begin
                        state_q <= MD_RUN;
                        cnt_q   <= '0;
                    end
                end
                MD_RUN: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == CNT_LAST) begin
                        state_q <= MD_FIXUP;
                    end
                end
                MD_FIXUP: state_q <= MD_DONE;
                MD_DONE:  state_q <= MD_IDLE;
                default:  state_q <= MD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == MD_IDLE && start_i) begin
            op_q     <= op_i;
            neg_q    <= start_neg;
            b_zero_q <= (op2_i == '0);
            opb_q    <= b_mag;
            acc_q    <= {{XW{1'b0}}, a_mag};
        end else if (state_q == MD_RUN) begin
            acc_q <= acc_step;
        end else if (state_q == MD_FIXUP) begin
            result_q <= fix_res;
        end
    end

    assign result_o = result_q;
    assign done_o   = state_q == MD_DONE;

endmodule

//--- hdl/ex_pkg.sv
`include "ex_defs.svh"

package ex_pkg;

    typedef enum logic [5:0] {
        OP_ADD, OP_SUB, OP_SLT, OP_SLTU, OP_XOR, OP_OR, OP_AND,
        OP_SLL, OP_SRL, OP_SRA,
        OP_ADDW, OP_SUBW, OP_SLLW, OP_SRLW, OP_SRAW,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU, OP_JAL,
        OP_MUL, OP_MULH, OP_MULHU, OP_DIV, OP_DIVU, OP_REM, OP_REMU
    } ex_op_e;

    typedef enum logic [1:0] {
        CLS_ALU,
        CLS_BRANCH,
        CLS_MULDIV
    } ex_cls_e;

    typedef enum logic [1:0] {
        MD_IDLE,
        MD_RUN,
        MD_FIXUP,
        MD_DONE
    } ex_md_state_e;

    typedef struct packed {
        ex_op_e               op;
        logic [`EX_XLEN-1:0]  op1;
        logic [`EX_XLEN-1:0]  op2;
        logic [`EX_XLEN-1:0]  pc;
        logic [`EX_XLEN-1:0]  imm;
        logic [4:0]           rd_addr;
        logic                 rd_ena;
    } ex_req_t;

    typedef struct packed {
        logic [`EX_XLEN-1:0]  rd_data;
        logic [4:0]           rd_addr;
        logic                 rd_ena;
        logic                 branch_taken;
        logic [`EX_XLEN-1:0]  branch_pc;
    } ex_res_t;

    // which unit handles an operation
    function automatic ex_cls_e ex_op_class(input ex_op_e op);
        case (op)
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU, OP_JAL: return CLS_BRANCH;
            OP_MUL, OP_MULH, OP_MULHU, OP_DIV, OP_DIVU, OP_REM, OP_REMU: return CLS_MULDIV;
            default: return CLS_ALU;
        endcase
    endfunction

endpackage

//--- hdl/ex_top.sv
`timescale 1ns/1ps
`include "ex_defs.svh"

module ex_top (
    input  logic            clk,
    input  logic            rst_n_i,

    input  ex_pkg::ex_req_t req_i,
    input  logic            req_valid_i,
    output logic            req_ready_o,

    output ex_pkg::ex_res_t res_o,
    output logic            res_valid_o,
    input  logic            res_ready_i
);

    import ex_pkg::*;

    ex_res_t             alu_res;
    logic                md_start;
    logic                md_done;
    logic [`EX_XLEN-1:0] md_result;

    ex_commit i_commit (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .req_i       (req_i),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .alu_res_i   (alu_res),
        .md_start_o  (md_start),
        .md_done_i   (md_done),
        .md_result_i (md_result),
        .res_o       (res_o),
        .res_valid_o (res_valid_o),
        .res_ready_i (res_ready_i)
    );

    ex_alu i_alu (
        .req_i (req_i),
        .res_o (alu_res)
    );

    // operands are sampled on the start pulse
    ex_muldiv i_muldiv (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .start_i  (md_start),
        .op_i     (req_i.op),
        .op1_i    (req_i.op1),
        .op2_i    (req_i.op2),
        .result_o (md_result),
        .done_o   (md_done)
    );

endmodule

//--- verification/ex_tb.sv
`timescale 1ns/1ps
`include "ex_defs.svh"

module ex_tb;

    import ex_pkg::*;

    logic    clk;
    logic    rst_n;
    ex_req_t req_i;
    logic    req_valid_i;
    logic    req_ready_o;
    ex_res_t res_o;
    logic    res_valid_o;
    logic    res_ready_i;

    logic [63:0] rng_state;
    ex_res_t     exp_q[$];
    ex_req_t     cur_req;
    bit          have_req;
    bit          alu_check_due;
    bit          md_inflight;
    int          md_wait;

    ex_tb_clk i_clk (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    ex_top i_dut (
        .clk         (clk),
        .rst_n_i     (rst_n),
        .req_i       (req_i),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .res_o       (res_o),
        .res_valid_o (res_valid_o),
        .res_ready_i (res_ready_i)
    );

    function automatic logic [63:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 7);
        rng_state = rng_state ^ (rng_state << 17);
        return rng_state;
    endfunction

    // corner values show up often
    function automatic logic [63:0] pick_operand();
        logic [63:0] r;
        r = next_rand();
        case (r[2:0])
            3'd0: return 64'd0;
            3'd1: return '1;
            3'd2: return 64'h8000_0000_0000_0000;
            3'd3: return {60'd0, r[7:4]};
            default: return next_rand();
        endcase
    endfunction

    function automatic bit is_muldiv(input ex_op_e op);
        case (op)
            OP_MUL, OP_MULH, OP_MULHU, OP_DIV, OP_DIVU, OP_REM, OP_REMU: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [63:0] sext32(input logic [31:0] v);
        return {{32{v[31]}}, v};
    endfunction

    // expected result from the execute stage rules
    function automatic ex_res_t model(input ex_req_t r);
        ex_res_t            e;
        logic [63:0]        a;
        logic [63:0]        b;
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic [127:0]       p;
        logic signed [31:0] aw;
        bit                 ovf;
        a   = r.op1;
        b   = r.op2;
        sa  = r.op1;
        sb  = r.op2;
        aw  = a[31:0];
        ovf = (a == 64'h8000_0000_0000_0000) && (b == '1);
        e   = '0;
        e.rd_addr = r.rd_addr;
        e.rd_ena  = r.rd_ena;
        case (r.op)
            OP_ADD:  e.rd_data = a + b;
            OP_SUB:  e.rd_data = a - b;
            OP_SLT:  e.rd_data = {63'd0, sa < sb};
            OP_SLTU: e.rd_data = {63'd0, a < b};
            OP_XOR:  e.rd_data = a ^ b;
            OP_OR:   e.rd_data = a | b;
            OP_AND:  e.rd_data = a & b;
            OP_SLL:  e.rd_data = a << b[5:0];
            OP_SRL:  e.rd_data = a >> b[5:0];
            OP_SRA:  e.rd_data = sa >>> b[5:0];
            OP_ADDW: e.rd_data = sext32(a[31:0] + b[31:0]);
            OP_SUBW: e.rd_data = sext32(a[31:0] - b[31:0]);
            OP_SLLW: e.rd_data = sext32(a[31:0] << b[4:0]);
            OP_SRLW: e.rd_data = sext32(a[31:0] >> b[4:0]);
            OP_SRAW: e.rd_data = sext32(aw >>> b[4:0]);
            OP_BEQ:  e.branch_taken = a == b;
            OP_BNE:  e.branch_taken = a != b;
            OP_BLT:  e.branch_taken = sa < sb;
            OP_BGE:  e.branch_taken = sa >= sb;
            OP_BLTU: e.branch_taken = a < b;
            OP_BGEU: e.branch_taken = a >= b;
            OP_JAL: begin
                e.branch_taken = 1'b1;
                e.rd_data      = r.pc + 64'd4;
            end
            OP_MUL: begin
                p = {64'd0, a} * {64'd0, b};
                e.rd_data = p[63:0];
            end
            OP_MULH: begin
                p = $signed({{64{a[63]}}, a}) * $signed({{64{b[63]}}, b});
                e.rd_data = p[127:64];
            end
            OP_MULHU: begin
                p = {64'd0, a} * {64'd0, b};
                e.rd_data = p[127:64];
            end
            OP_DIV:  e.rd_data = (b == 0) ? '1 : (ovf ? a : 64'(sa / sb));
            OP_DIVU: e.rd_data = (b == 0) ? '1 : a / b;
            OP_REM:  e.rd_data = (b == 0) ? a : (ovf ? 64'd0 : 64'(sa % sb));
            OP_REMU: e.rd_data = (b == 0) ? a : a % b;
            default: e.rd_data = '0;
        endcase
        if (e.branch_taken) begin
            e.branch_pc = r.pc + r.imm;
        end
        return e;
    endfunction

    task automatic abort_run(input string what);
        $display("Error: %s", what);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            $display("TESTS FAILED");
            $fatal(1);
        end
    endtask

    // reset release, sampled just after a falling edge
    task automatic wait_reset_release();
        int waited;
        waited = 0;
        while (rst_n !== 1'b1) begin
            @(negedge clk);
            #1;
            waited++;
            if (waited > 20) begin
                abort_run("reset was never released");
            end
        end
    endtask

    task automatic compare_result(input string name);
        ex_res_t e;
        if (exp_q.size() == 0) begin
            abort_run("a result arrived with no request outstanding");
        end
        e = exp_q.pop_front();
        check_val({name, " rd_data"}, e.rd_data, res_o.rd_data);
        check_val({name, " rd_addr"}, 64'(e.rd_addr), 64'(res_o.rd_addr));
        check_val({name, " rd_ena"}, 64'(e.rd_ena), 64'(res_o.rd_ena));
        check_val({name, " branch_taken"}, 64'(e.branch_taken), 64'(res_o.branch_taken));
        check_val({name, " branch_pc"}, e.branch_pc, res_o.branch_pc);
    endtask

    // one clock of observing outputs and driving inputs
    task automatic run_cycle(input bit bp, input string name);
        logic [63:0] r;
        @(negedge clk);
        if (alu_check_due) begin
            check_val({name, " one cycle latency"}, 1, 64'(res_valid_o));
            alu_check_due = 1'b0;
        end
        if (md_inflight) begin
            if (res_valid_o) begin
                md_inflight = 1'b0;
            end else begin
                md_wait++;
                if (md_wait > 4 * `EX_MD_STEPS) begin
                    abort_run("multiply/divide result never became valid");
                end
            end
        end
        r = next_rand();
        res_ready_i = bp ? r[0] : 1'b1;
        if (res_valid_o && res_ready_i) begin
            compare_result(name);
        end
        req_valid_i = have_req;
        req_i       = cur_req;
        #1;
        if (md_inflight && req_ready_o) begin
            abort_run("request ready while a multiply/divide is in flight");
        end
        if (have_req && req_ready_o) begin
            exp_q.push_back(model(cur_req));
            if (is_muldiv(cur_req.op)) begin
                md_inflight = 1'b1;
                md_wait     = 0;
            end else begin
                alu_check_due = 1'b1;
            end
            have_req = 1'b0;
        end
    endtask

    task automatic send_req(input ex_req_t r, input bit bp, input string name);
        int waited;
        cur_req  = r;
        have_req = 1'b1;
        waited   = 0;
        while (have_req) begin
            run_cycle(bp, name);
            waited++;
            if (waited > 8 * `EX_MD_STEPS) begin
                abort_run("request was never accepted");
            end
        end
    endtask

    task automatic drain(input bit bp, input string name);
        int waited;
        waited = 0;
        while (exp_q.size() > 0 || md_inflight) begin
            run_cycle(bp, name);
            waited++;
            if (waited > 16 * `EX_MD_STEPS) begin
                abort_run("expected results never arrived");
            end
        end
        run_cycle(bp, name);
    endtask

    // kind 0 alu, 1 branch, 2 multiply/divide, 3 mixed
    task automatic run_phase(input int n, input int kind, input bit bp, input string name);
        ex_req_t r;
        int      k;
        for (int i = 0; i < n; i++) begin
            k = (kind == 3) ? int'(next_rand() % 3) : kind;
            r.op1     = pick_operand();
            r.op2     = pick_operand();
            r.pc      = next_rand() & ~64'd3;
            r.imm     = next_rand();
            r.rd_addr = 5'(next_rand());
            r.rd_ena  = 1'(next_rand());
            case (k)
                0: r.op = ex_op_e'(6'(next_rand() % 15));
                1: r.op = ex_op_e'(6'(15 + next_rand() % 7));
                default: r.op = ex_op_e'(6'(22 + next_rand() % 7));
            endcase
            if (kind == 2 && i < 4) begin
                r.op  = (i == 0) ? OP_DIV : (i == 1) ? OP_REM : (i == 2) ? OP_DIVU : OP_REMU;
                r.op2 = '0;
            end else if (kind == 2 && i < 6) begin
                r.op  = (i == 4) ? OP_DIV : OP_REM;
                r.op1 = 64'h8000_0000_0000_0000;
                r.op2 = '1;
            end
            send_req(r, bp, name);
            if (bp && next_rand() % 4 == 0) begin
                run_cycle(bp, name);
            end
        end
        drain(bp, name);
    endtask

    initial begin
        rng_state     = 64'd43;
        req_i         = '0;
        req_valid_i   = 1'b0;
        res_ready_i   = 1'b0;
        cur_req       = '0;
        have_req      = 1'b0;
        alu_check_due = 1'b0;
        md_inflight   = 1'b0;
        md_wait       = 0;

        wait_reset_release();
        check_val("reset res_valid_o", 0, 64'(res_valid_o));
        check_val("reset req_ready_o", 1, 64'(req_ready_o));

        run_phase(300, 0, 1'b0, "alu");
        run_phase(200, 1, 1'b0, "branch");
        run_phase(60, 2, 1'b0, "muldiv");
        run_phase(150, 3, 1'b1, "backpressure");

        $display("TESTS PASSED");
        $finish;
    end

endmodule

//--- verification/ex_tb_clk.sv
`timescale 1ns/1ps

module ex_tb_clk (
    output logic clk_o,
    output logic rst_n_o
);

    // 8 ns period
    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;
    end

    // reset held for 5 cycles, released on a falling edge
    initial begin
        rst_n_o = 1'b0;
        repeat (5) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule
